// File: all.f
+incdir+.
link_pkg.sv
link_reset_sync.sv
serial_tx_8b9b.sv
serial_rx_8b9b.sv
k7_s6_link.sv
link_checker.sv
tb_k7_s6_link.sv

// File: k7_s6_link.sv
`timescale 1ns/1ps
`default_nettype none

module k7_s6_link (
	input  wire logic            clk,
	input  wire logic            arst_n,

	// Port 6
	input  wire link_pkg::word_t p6_word_tx,
	input  wire logic            p6_tx_last,
	input  wire logic            p6_tx_available,
	output wire logic            p6_word_read,
	output wire logic            p6_line_out,
	input  wire logic            p6_line_in,
	output link_pkg::word_t      p6_word_rx,
	output wire logic            p6_rx_write,
	output wire logic            p6_rx_complete,

	// Port 7
	input  wire link_pkg::word_t p7_word_tx,
	input  wire logic            p7_tx_last,
	input  wire logic            p7_tx_available,
	output wire logic            p7_word_read,
	output wire logic            p7_line_out,
	input  wire logic            p7_line_in,
	output link_pkg::word_t      p7_word_rx,
	output wire logic            p7_rx_write,
	output wire logic            p7_rx_complete,

	output wire logic            link_ready
);

	wire logic link_rst_n; // Shared by every transmitter and receiver.

	assign link_ready = link_rst_n;

	link_reset_sync u_reset (
		.clk        (clk),
		.arst_n     (arst_n),
		.link_rst_n (link_rst_n)
	);

	// ====================
	// Port 6
	// ====================
	serial_tx_8b9b u_p6_tx (
		.clk            (clk),
		.arst_n         (link_rst_n),
		.word           (p6_word_tx),
		.last           (p6_tx_last),
		.word_available (p6_tx_available),
		.word_read      (p6_word_read),
		.line           (p6_line_out)
	);

	serial_rx_8b9b u_p6_rx (
		.clk            (clk),
		.arst_n         (link_rst_n),
		.line           (p6_line_in),
		.word           (p6_word_rx),
		.word_write     (p6_rx_write),
		.frame_complete (p6_rx_complete)
	);

	// ====================
	// Port 7
	// ====================
	serial_tx_8b9b u_p7_tx (
		.clk            (clk),
		.arst_n         (link_rst_n),
		.word           (p7_word_tx),
		.last           (p7_tx_last),
		.word_available (p7_tx_available),
		.word_read      (p7_word_read),
		.line           (p7_line_out)
	);

	serial_rx_8b9b u_p7_rx (
		.clk            (clk),
		.arst_n         (link_rst_n),
		.line           (p7_line_in),
		.word           (p7_word_rx),
		.word_write     (p7_rx_write),
		.frame_complete (p7_rx_complete)
	);

endmodule

`default_nettype wire

// File: link_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module link_checker (
	input wire logic                clk,
	input wire logic                arst_n,
	input wire logic                link_ready,
	input wire logic                p6_tx_available,
	input wire logic                p6_word_read,
	input wire logic                p6_line_out,
	input wire link_pkg::word_t     p6_word_rx,
	input wire logic                p6_rx_write,
	input wire logic                p6_rx_complete,
	input wire logic                p7_tx_available,
	input wire logic                p7_word_read,
	input wire logic                p7_line_out,
	input wire link_pkg::word_t     p7_word_rx,
	input wire logic                p7_rx_write,
	input wire logic                p7_rx_complete,
	input wire link_pkg::tx_state_t p6_tx_state,
	input wire link_pkg::tx_state_t p7_tx_state,
	input wire link_pkg::rx_state_t p6_rx_state,
	input wire link_pkg::rx_state_t p7_rx_state
);

	localparam int SYMBOL_CYCLES = 11 * `LINK_OVERSAMPLE;

	// Expected entries are {port, frame_complete, word}, one queue per port.
	logic [9:0] exp6[$];
	logic [9:0] exp7[$];
	string      test_name;
	int         err_count;
	int         test_errors;
	int         tests_run;
	int         total_words;
	int         exp_words;
	int         exp_frames;
	int         got_words;
	int         got_frames;
	int         cycle;
	int         rst_cycles;
	bit         rst_reported;
	int         last_read[2];
	bit         held[2]; // word_available stayed high since the last word_read.

	function automatic int pending_count();
		return exp6.size() + exp7.size();
	endfunction

	function automatic int error_count();
		return err_count;
	endfunction

	task automatic note_error();
		err_count++;
		test_errors++;
	endtask

	task automatic fail_plain(input string msg);
		$display("Test %s: %s", test_name, msg);
		note_error();
	endtask

	// ====================
	// Test bookkeeping
	// ====================
	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
		exp_words   = 0;
		exp_frames  = 0;
		got_words   = 0;
		got_frames  = 0;
	endtask

	task automatic expect_entry(input logic [9:0] entry);
		if (entry[9]) begin
			exp7.push_back(entry);
		end else begin
			exp6.push_back(entry);
		end
		exp_words++;
		if (entry[8]) exp_frames++;
	endtask

	task automatic end_test();
		if (exp6.size() != 0) begin
			fail_plain($sformatf("port 6 never delivered %0d words, receiver left in %s",
				exp6.size(), p6_rx_state.name()));
		end
		if (exp7.size() != 0) begin
			fail_plain($sformatf("port 7 never delivered %0d words, receiver left in %s",
				exp7.size(), p7_rx_state.name()));
		end
		exp6.delete();
		exp7.delete();
		if (got_words != exp_words) begin
			$display("ERROR test %s word count: expected %0d, actual %0d",
				test_name, exp_words, got_words);
			note_error();
		end
		if (got_frames != exp_frames) begin
			$display("ERROR test %s frame count: expected %0d, actual %0d",
				test_name, exp_frames, got_frames);
			note_error();
		end
		tests_run++;
		total_words += got_words;
		$display("Test %s done: %0d words, %0d frames, %0d errors",
			test_name, got_words, got_frames, test_errors);
	endtask

	task automatic summary();
		$display("Summary: %0d tests, %0d words received, %0d errors",
			tests_run, total_words, err_count);
	endtask

	// ====================
	// Per-port checks
	// ====================
	task automatic check_rx(input bit port, input logic write, input logic complete,
		input link_pkg::word_t word);
		logic [9:0] expected;
		logic [9:0] actual;
		actual = {port, complete, word};
		if (complete && !write) begin
			fail_plain($sformatf("port %0d raised frame_complete without word_write", port + 6));
		end
		if (write) begin
			got_words++;
			if (complete) got_frames++;
			if ((port ? exp7.size() : exp6.size()) == 0) begin
				fail_plain($sformatf("port %0d wrote word %02h that nobody sent", port + 6, word));
			end else begin
				if (port) expected = exp7.pop_front();
				else expected = exp6.pop_front();
				if (expected !== actual) begin
					$display("ERROR test %s port %0d: expected %02h complete %0b, actual %02h complete %0b",
						test_name, port + 6, expected[7:0], expected[8], word, complete);
					note_error();
				end
			end
		end
	endtask

	task automatic check_read(input bit port, input logic read, input logic avail,
		input logic line, input link_pkg::tx_state_t tx_state);
		int gap;
		if (line && tx_state == link_pkg::TX_IDLE) begin
			fail_plain($sformatf("port %0d line is high while its transmitter is idle", port + 6));
		end
		if (read) begin
			gap = cycle - last_read[port];
			if (held[port] && gap != SYMBOL_CYCLES) begin
				$display("ERROR test %s port %0d word_read spacing: expected %0d, actual %0d (%s)",
					test_name, port + 6, SYMBOL_CYCLES, gap, tx_state.name());
				note_error();
			end
			last_read[port] = cycle;
			held[port]      = avail;
		end else if (!avail) begin
			held[port] = 1'b0;
		end
	endtask

	// Registered DUT outputs are read at the rising edge, before they update.
	initial begin
		err_count    = 0;
		tests_run    = 0;
		total_words  = 0;
		cycle        = 0;
		rst_cycles   = 0;
		rst_reported = 1'b0;
		held         = '{1'b0, 1'b0};
		last_read    = '{0, 0};
		forever begin
			@(posedge clk);
			cycle++;
			if (!arst_n) begin
				rst_cycles   = 0;
				rst_reported = 1'b0;
			end else if (!link_ready) begin
				rst_cycles++;
			end
			if (link_ready === 1'b0) begin
				if (p6_line_out || p7_line_out || p6_word_read || p7_word_read ||
					p6_rx_write || p7_rx_write || p6_rx_complete || p7_rx_complete) begin
					fail_plain("a line or strobe was active while the link was in reset");
				end
			end else if (link_ready === 1'b1) begin
				if (!rst_reported) begin
					rst_reported = 1'b1;
					if (rst_cycles != `LINK_RESET_HOLD + 2) begin
						$display("ERROR test %s link_ready delay: expected %0d, actual %0d",
							test_name, `LINK_RESET_HOLD + 2, rst_cycles);
						note_error();
					end
				end
				check_rx(1'b0, p6_rx_write, p6_rx_complete, p6_word_rx);
				check_rx(1'b1, p7_rx_write, p7_rx_complete, p7_word_rx);
				check_read(1'b0, p6_word_read, p6_tx_available, p6_line_out, p6_tx_state);
				check_read(1'b1, p7_word_read, p7_tx_available, p7_line_out, p7_tx_state);
			end
		end
	end

endmodule

`default_nettype wire

// File: link_macros.svh
`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

// ====================
// Link word format
// ====================

// Data bits carried by one symbol.
`define LINK_WORD_BITS 8

// Clock cycles per line bit. Keep this at 2 or more so the receiver has a mid-bit sample.
`define LINK_OVERSAMPLE 4

// ====================
// Reset release
// ====================

`define LINK_RESET_HOLD 16 // Extra cycles after the synchronizer before the link leaves reset.

`endif

// File: link_pkg.sv
`default_nettype none

package link_pkg;

	`include "link_macros.svh"

	// One payload word as it crosses the link.
	typedef logic [`LINK_WORD_BITS-1:0] word_t;

	// Transmitter symbol phases, in the order they appear on the line.
	typedef enum logic [2:0] {
		TX_IDLE,  // Line held low, waiting for word_available.
		TX_START, // Start bit of 1.
		TX_DATA,  // Data bits, MSB first.
		TX_LAST,  // End-of-frame flag.
		TX_GUARD  // Guard bit of 0.
	} tx_state_t;

	// Receiver phases.
	typedef enum logic [1:0] {
		RX_IDLE,        // Waiting for a rising edge.
		RX_START_CHECK, // Confirming the start bit at mid-bit.
		RX_DATA,        // Sampling the data bits.
		RX_LAST         // Sampling the flag, then emitting the word.
	} rx_state_t;

endpackage

`default_nettype wire

// File: link_reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module link_reset_sync (
	input  wire logic clk,
	input  wire logic arst_n,
	output logic      link_rst_n
);

	localparam int HOLD  = `LINK_RESET_HOLD;
	localparam int CNT_W = $clog2(HOLD + 1);

	logic [1:0]       sync_q;   // Release synchronizer.
	logic [CNT_W-1:0] hold_cnt; // Cycles spent since the synchronized release.

	// The link reset drops together with arst_n. Release waits for two
	// synchronizer stages and then HOLD more cycles.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q     <= '0;
			hold_cnt   <= '0;
			link_rst_n <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
			if (!link_rst_n && sync_q[1]) begin
				if (hold_cnt == CNT_W'(HOLD - 1)) begin
					link_rst_n <= 1'b1;
				end else begin
					hold_cnt <= hold_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Builds the link testbench with Verilator, runs it and scans the log for the result.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_k7_s6_link -f all.f -o tb_k7_s6_link \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_k7_s6_link > sim.log 2>&1
cat sim.log

grep -q "TESTS PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: serial_rx_8b9b.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module serial_rx_8b9b (
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire logic       line,
	output link_pkg::word_t word,
	output logic            word_write,
	output logic            frame_complete
);

	localparam int OS    = `LINK_OVERSAMPLE;
	localparam int W     = `LINK_WORD_BITS;
	localparam int CNT_W = $clog2(OS);
	localparam int BIT_W = $clog2(W);

	link_pkg::rx_state_t state;
	logic [1:0]          line_sync; // Two-stage synchronizer for the incoming line.
	logic                line_prev; // Previous synchronized value, for edge detection.
	logic [CNT_W-1:0]    cnt;       // Cycle within the current line bit.
	logic [BIT_W-1:0]    bit_idx;   // Data bit being sampled.
	logic [W-1:0]        data_q;
	logic                line_s;
	logic                rise;
	logic                half_bit;
	logic                bit_end;
	logic                sample_data;

	assign line_s = line_sync[1];
	assign rise   = line_s & ~line_prev;

	// The start bit is confirmed OS/2 cycles into it. Every later
	// sample falls a whole bit period after the previous one, so it
	// also lands near the middle of its bit.
	assign half_bit = (cnt == CNT_W'(OS / 2 - 1));
	assign bit_end  = (cnt == CNT_W'(OS - 1));

	assign sample_data = (state == link_pkg::RX_DATA) && bit_end;

	assign word = data_q; // Valid in the cycle word_write is high.

	// ====================
	// Receive FSM
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			line_sync      <= '0;
			line_prev      <= 1'b0;
			state          <= link_pkg::RX_IDLE;
			cnt            <= '0;
			bit_idx        <= '0;
			word_write     <= 1'b0;
			frame_complete <= 1'b0;
		end else begin
			line_sync      <= {line_sync[0], line};
			line_prev      <= line_s;
			word_write     <= 1'b0;
			frame_complete <= 1'b0;
			case (state)
				link_pkg::RX_IDLE: begin
					if (rise) begin
						state <= link_pkg::RX_START_CHECK;
						cnt   <= '0;
					end
				end
				link_pkg::RX_START_CHECK: begin
					if (half_bit) begin
						cnt     <= '0;
						bit_idx <= '0;
						// A line that has fallen again was only a glitch.
						if (line_s) begin
							state <= link_pkg::RX_DATA;
						end else begin
							state <= link_pkg::RX_IDLE;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				link_pkg::RX_DATA: begin
					if (bit_end) begin
						cnt <= '0;
						if (bit_idx == BIT_W'(W - 1)) begin
							state <= link_pkg::RX_LAST;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				link_pkg::RX_LAST: begin
					if (bit_end) begin
						word_write     <= 1'b1;
						frame_complete <= line_s; // The sampled flag closes the frame.
						cnt            <= '0;
						// The guard bit that follows keeps the line low, so the
						// next start bit always shows up as a fresh rising edge.
						state <= link_pkg::RX_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= link_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// Data bits arrive MSB first.
	always_ff @(posedge clk) begin
		if (sample_data) begin
			data_q <= {data_q[W-2:0], line_s};
		end
	end

endmodule

`default_nettype wire

// File: serial_tx_8b9b.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module serial_tx_8b9b (
	input  wire logic            clk,
	input  wire logic            arst_n,
	input  wire link_pkg::word_t word,
	input  wire logic            last,
	input  wire logic            word_available,
	output logic                 word_read,
	output logic                 line
);

	localparam int OS    = `LINK_OVERSAMPLE;
	localparam int W     = `LINK_WORD_BITS;
	localparam int CNT_W = $clog2(OS);
	localparam int BIT_W = $clog2(W);

	link_pkg::tx_state_t state;
	logic [CNT_W-1:0]    cnt;     // Cycle within the current line bit.
	logic [BIT_W-1:0]    bit_idx; // Data bit being sent.
	logic [W-1:0]        shift_q; // Remaining data bits, next one at the top.
	logic                last_q;  // Flag latched with the word.
	logic                bit_end;
	logic                take_word;
	logic                shift_en;

	assign bit_end = (cnt == CNT_W'(OS - 1));

	// A word is taken from idle, or right at the end of a guard bit so
	// that a held word_available gives back-to-back symbols.
	assign take_word = word_available &&
		((state == link_pkg::TX_IDLE) || ((state == link_pkg::TX_GUARD) && bit_end));

	// The shift register moves whenever a new data bit goes onto the line.
	assign shift_en = bit_end && ((state == link_pkg::TX_START) ||
		((state == link_pkg::TX_DATA) && (bit_idx != BIT_W'(W - 1))));

	// ====================
	// Symbol sequencer
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= link_pkg::TX_IDLE;
			cnt       <= '0;
			bit_idx   <= '0;
			word_read <= 1'b0;
			line      <= 1'b0;
		end else begin
			word_read <= take_word; // High for the one cycle after the word is taken.
			if (take_word) begin
				state <= link_pkg::TX_START;
				cnt   <= '0;
				line  <= 1'b1; // Start bit.
			end else if (state != link_pkg::TX_IDLE) begin
				if (!bit_end) begin
					cnt <= cnt + 1'b1;
				end else begin
					cnt <= '0;
					case (state)
						link_pkg::TX_START: begin
							state   <= link_pkg::TX_DATA;
							bit_idx <= '0;
							line    <= shift_q[W-1];
						end
						link_pkg::TX_DATA: begin
							if (bit_idx == BIT_W'(W - 1)) begin
								state <= link_pkg::TX_LAST;
								line  <= last_q;
							end else begin
								bit_idx <= bit_idx + 1'b1;
								line    <= shift_q[W-1];
							end
						end
						link_pkg::TX_LAST: begin
							state <= link_pkg::TX_GUARD;
							line  <= 1'b0; // Guard bit.
						end
						default: begin
							// Guard finished and nothing waiting.
							state <= link_pkg::TX_IDLE;
							line  <= 1'b0;
						end
					endcase
				end
			end
		end
	end

	// Payload path.
	always_ff @(posedge clk) begin
		if (take_word) begin
			shift_q <= word;
			last_q  <= last;
		end else if (shift_en) begin
			shift_q <= {shift_q[W-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: tb_k7_s6_link.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module tb_k7_s6_link;

	localparam int SYMBOL_CYCLES  = 11 * `LINK_OVERSAMPLE;
	localparam int TOTAL_WORDS    = 1 + 8 + 12 + 3 + 2 * 20 * 6; // Worst case over all tests.
	localparam int TIMEOUT_CYCLES = TOTAL_WORDS * SYMBOL_CYCLES * 2 + 2000;

	typedef link_pkg::word_t word_q_t[$];
	typedef int len_q_t[$];
	typedef logic [9:0] exp_q_t[$];

	logic            clk;
	logic            arst_n;
	link_pkg::word_t p6_word_tx;
	link_pkg::word_t p7_word_tx;
	logic            p6_tx_last;
	logic            p7_tx_last;
	logic            p6_tx_available;
	logic            p7_tx_available;
	logic            p6_inject_en;  // Overrides the loopback on port 6.
	logic            p6_inject_val;
	logic            p7_inject_en;
	logic            p7_inject_val;
	wire logic       p6_word_read;
	wire logic       p7_word_read;
	wire logic       p6_line_out;
	wire logic       p7_line_out;
	wire logic       p6_line_in;
	wire logic       p7_line_in;
	wire link_pkg::word_t p6_word_rx;
	wire link_pkg::word_t p7_word_rx;
	wire logic       p6_rx_write;
	wire logic       p7_rx_write;
	wire logic       p6_rx_complete;
	wire logic       p7_rx_complete;
	wire logic       link_ready;
	int              cycles;
	int unsigned     seed_value;

	assign p6_line_in = p6_inject_en ? p6_inject_val : p6_line_out;
	assign p7_line_in = p7_inject_en ? p7_inject_val : p7_line_out;

	k7_s6_link dut (
		.clk (clk), .arst_n (arst_n),
		.p6_word_tx (p6_word_tx), .p6_tx_last (p6_tx_last),
		.p6_tx_available (p6_tx_available), .p6_word_read (p6_word_read),
		.p6_line_out (p6_line_out), .p6_line_in (p6_line_in), .p6_word_rx (p6_word_rx),
		.p6_rx_write (p6_rx_write), .p6_rx_complete (p6_rx_complete),
		.p7_word_tx (p7_word_tx), .p7_tx_last (p7_tx_last),
		.p7_tx_available (p7_tx_available), .p7_word_read (p7_word_read),
		.p7_line_out (p7_line_out), .p7_line_in (p7_line_in), .p7_word_rx (p7_word_rx),
		.p7_rx_write (p7_rx_write), .p7_rx_complete (p7_rx_complete),
		.link_ready (link_ready)
	);

	link_checker chk (
		.clk (clk), .arst_n (arst_n), .link_ready (link_ready),
		.p6_tx_available (p6_tx_available), .p6_word_read (p6_word_read),
		.p6_line_out (p6_line_out), .p6_word_rx (p6_word_rx),
		.p6_rx_write (p6_rx_write), .p6_rx_complete (p6_rx_complete),
		.p7_tx_available (p7_tx_available), .p7_word_read (p7_word_read),
		.p7_line_out (p7_line_out), .p7_word_rx (p7_word_rx),
		.p7_rx_write (p7_rx_write), .p7_rx_complete (p7_rx_complete),
		.p6_tx_state (dut.u_p6_tx.state), .p7_tx_state (dut.u_p7_tx.state),
		.p6_rx_state (dut.u_p6_rx.state), .p7_rx_state (dut.u_p7_rx.state)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Each word of a frame is expected in order; only the last one closes the frame.
	function automatic exp_q_t expected_sequence(input bit port, input word_q_t words,
		input len_q_t lens);
		exp_q_t seq;
		int     idx;
		int     i;
		idx = 0;
		foreach (lens[f]) begin
			for (i = 0; i < lens[f]; i++) begin
				seq.push_back({port, (i == lens[f] - 1), words[idx]});
				idx++;
			end
		end
		return seq;
	endfunction

	// ====================
	// Stimulus
	// ====================
	task automatic drive_tx(input bit port, input link_pkg::word_t word, input logic last,
		input logic avail);
		if (port) begin
			p7_word_tx      = word;
			p7_tx_last      = last;
			p7_tx_available = avail;
		end else begin
			p6_word_tx      = word;
			p6_tx_last      = last;
			p6_tx_available = avail;
		end
	endtask

	task automatic wait_read(input bit port);
		@(negedge clk);
		while (!(port ? p7_word_read : p6_word_read)) @(negedge clk);
	endtask

	task automatic send_frames(input bit port, input word_q_t words, input len_q_t lens,
		input int max_gap);
		int idx;
		int i;
		int gap;
		idx = 0;
		foreach (lens[f]) begin
			for (i = 0; i < lens[f]; i++) begin
				drive_tx(port, words[idx], (i == lens[f] - 1), 1'b1);
				idx++;
				wait_read(port); // The next word goes up as soon as this one is taken.
			end
			gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
			if (gap > 0) begin
				drive_tx(port, '0, 1'b0, 1'b0);
				repeat (gap) @(negedge clk);
			end
		end
		drive_tx(port, '0, 1'b0, 1'b0);
	endtask

	task automatic build_random_frames(input int n_frames, input int min_len, input int max_len,
		output word_q_t words, output len_q_t lens);
		int f;
		int i;
		int len;
		words.delete();
		lens.delete();
		for (f = 0; f < n_frames; f++) begin
			len = int'($urandom_range(max_len, min_len));
			lens.push_back(len);
			for (i = 0; i < len; i++) words.push_back(link_pkg::word_t'($urandom));
		end
	endtask

	task automatic queue_expected(input bit port, input word_q_t words, input len_q_t lens);
		exp_q_t seq;
		seq = expected_sequence(port, words, lens);
		foreach (seq[k]) chk.expect_entry(seq[k]);
	endtask

	// Gives the last words two symbols to arrive, then watches two more for stray strobes.
	task automatic wait_drained();
		int waited;
		waited = 0;
		while (chk.pending_count() != 0 && waited < 2 * SYMBOL_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		repeat (2 * SYMBOL_CYCLES) @(negedge clk);
	endtask

	task automatic run_test(input string name, input word_q_t w6, input len_q_t l6,
		input word_q_t w7, input len_q_t l7, input int max_gap);
		chk.begin_test(name);
		queue_expected(1'b0, w6, l6);
		queue_expected(1'b1, w7, l7);
		fork
			send_frames(1'b0, w6, l6, max_gap);
			send_frames(1'b1, w7, l7, max_gap);
		join
		wait_drained();
		chk.end_test();
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		word_q_t w6;
		word_q_t w7;
		word_q_t no_words;
		len_q_t  l6;
		len_q_t  l7;
		len_q_t  no_lens;
		seed_value    = $urandom(80);
		arst_n        = 1'b0;
		p6_inject_en  = 1'b0;
		p6_inject_val = 1'b0;
		p7_inject_en  = 1'b0;
		p7_inject_val = 1'b0;
		drive_tx(1'b0, '0, 1'b0, 1'b0);
		drive_tx(1'b1, '0, 1'b0, 1'b0);

		chk.begin_test("reset");
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		while (link_ready !== 1'b1) @(negedge clk);
		repeat (2 * SYMBOL_CYCLES) @(negedge clk); // Quiet lines right after reset.
		chk.end_test();

		w6 = '{8'h5a};
		l6 = '{1};
		run_test("single_word_p6", w6, l6, no_words, no_lens, 0);

		build_random_frames(1, 8, 8, w7, l7);
		run_test("frame_p7", no_words, no_lens, w7, l7, 0);

		build_random_frames(2, 3, 3, w6, l6);
		build_random_frames(2, 3, 3, w7, l7);
		run_test("both_ports", w6, l6, w7, l7, 5);

		// A single-cycle pulse on either line must die in the start-bit check.
		chk.begin_test("glitch_reject");
		p6_inject_en  = 1'b1;
		p6_inject_val = 1'b1;
		p7_inject_en  = 1'b1;
		p7_inject_val = 1'b1;
		@(negedge clk);
		p6_inject_val = 1'b0;
		p7_inject_val = 1'b0;
		repeat (2 * SYMBOL_CYCLES) @(negedge clk);
		p6_inject_en = 1'b0;
		p7_inject_en = 1'b0;
		wait_drained();
		chk.end_test();

		build_random_frames(1, 3, 3, w6, l6);
		run_test("after_glitch_p6", w6, l6, no_words, no_lens, 0);

		build_random_frames(20, 1, 6, w6, l6);
		build_random_frames(20, 1, 6, w7, l7);
		run_test("random_stress", w6, l6, w7, l7, 30);

		chk.summary();
		if (chk.error_count() == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
